//--- hw/pes_defines.svh
`ifndef PES_DEFINES_SVH
`define PES_DEFINES_SVH

`define PES_QUEUE_DEPTH 4

`define PES_APB_AW 8

// byte addresses of the 32-bit registers
`define PES_REG_STATUS  8'h00
`define PES_REG_HDR     8'h04
`define PES_REG_PTS_LO  8'h08
`define PES_REG_DTS_LO  8'h0C
`define PES_REG_TS_MISC 8'h10
`define PES_REG_POP     8'h14
`define PES_REG_ERRCNT  8'h18

`define PES_PACKET_START  24'h00_0001
`define PES_PTS_BYTES     4'd5
`define PES_PTS_DTS_BYTES 4'd10

`endif

//--- hw/pes_stream_pkg.sv
package pes_stream_pkg;

  // PTS_DTS_flags from the second flags byte of the PES header
  typedef enum logic [1:0] {
    TS_NONE      = 2'b00,
    TS_FORBIDDEN = 2'b01,
    TS_PTS       = 2'b10,
    TS_PTS_DTS   = 2'b11
  } ts_mode_e;

  typedef struct packed {
    logic [7:0] stream_id;
    ts_mode_e   ts_mode;
    logic [7:0] header_data_length;
    logic       header_error;
  } pes_header_t;

  typedef struct packed {
    logic [32:0] pts;
    logic [32:0] dts;
    logic        has_dts;
    logic        marker_error;
  } ts_record_t;

  // one timestamp byte forwarded from the parser to the extractor
  typedef struct packed {
    logic       valid;
    ts_mode_e   mode;
    logic [7:0] data;
  } ts_req_t;

endpackage

//--- hw/pes_regs_pkg.sv
`include "pes_defines.svh"

package pes_regs_pkg;

  typedef struct packed {
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`PES_APB_AW-1:0] paddr;
    logic [31:0]            pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  typedef struct packed {
    logic [21:0] reserved;
    logic        ts_ovf;
    logic        hdr_ovf;
    logic [3:0]  ts_count;
    logic [3:0]  hdr_count;
  } pes_status_t;

endpackage

//--- hw/pes_header_parser.sv
`timescale 1ns/100ps
`include "pes_defines.svh"

module pes_header_parser (
  input  logic                        read_signal,
  input  logic                        rst_n,
  input  logic                        byte_valid,
  input  logic [7:0]                  stream_byte,
  output pes_stream_pkg::ts_req_t     ts_req,
  output logic                        hdr_push,
  output pes_stream_pkg::pes_header_t hdr_rec
);
  import pes_stream_pkg::*;

  localparam logic [23:0] START_CODE = `PES_PACKET_START;

  typedef enum logic [3:0] {
    S_SYNC0, S_SYNC1, S_SYNC2, S_STREAM_ID, S_LEN_HI,
    S_LEN_LO, S_FLAGS1, S_FLAGS2, S_HDR_LEN, S_BODY
  } state_e;

  state_e     state;
  logic [7:0] bytes_left;
  logic [3:0] ts_left;
  logic [3:0] ts_need;
  logic       hdr_bad;
  logic       fwd_valid;
  ts_mode_e   fwd_mode;
  logic [7:0] fwd_data;
  logic [7:0] stream_id_q;
  ts_mode_e   mode_q;
  logic [7:0] hdl_q;
  logic       error_q;

  assign ts_need = (mode_q == TS_PTS_DTS) ? `PES_PTS_DTS_BYTES :
                   (mode_q == TS_PTS)     ? `PES_PTS_BYTES : 4'd0;
  // a header too short to hold its own timestamps is rejected as well
  assign hdr_bad = error_q || (stream_byte < {4'd0, ts_need});

  always_ff @(posedge read_signal or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state      <= S_SYNC0;
      bytes_left <= 8'd0;
      ts_left    <= 4'd0;
      fwd_valid  <= 1'b0;
      hdr_push   <= 1'b0;
    end
    else
    begin
      hdr_push  <= 1'b0;
      fwd_valid <= byte_valid && (state == S_BODY) && (ts_left != 4'd0);
      if (byte_valid)
      begin
        case (state)
          S_SYNC0:
            if (stream_byte == START_CODE[23:16])
              state <= S_SYNC1;
          S_SYNC1:
            state <= (stream_byte == START_CODE[15:8]) ? S_SYNC2 : S_SYNC0;
          S_SYNC2:
            if (stream_byte == START_CODE[7:0])
              state <= S_STREAM_ID;
            else if (stream_byte != START_CODE[15:8])
              state <= S_SYNC0; // extra zero bytes keep the prefix alive
          S_STREAM_ID: state <= S_LEN_HI;
          S_LEN_HI:    state <= S_LEN_LO;
          S_LEN_LO:    state <= S_FLAGS1;
          S_FLAGS1:    state <= S_FLAGS2;
          S_FLAGS2:    state <= S_HDR_LEN;
          S_HDR_LEN:
          begin
            hdr_push   <= 1'b1;
            bytes_left <= stream_byte;
            ts_left    <= hdr_bad ? 4'd0 : ts_need;
            state      <= (stream_byte == 8'd0) ? S_SYNC0 : S_BODY;
          end
          S_BODY:
          begin
            bytes_left <= bytes_left - 8'd1;
            if (ts_left != 4'd0)
              ts_left <= ts_left - 4'd1;
            if (bytes_left == 8'd1)
              state <= S_SYNC0;
          end
          default: state <= S_SYNC0;
        endcase
      end
    end
  end

  always_ff @(posedge read_signal)
  begin
    if (byte_valid)
    begin
      fwd_data <= stream_byte;
      fwd_mode <= mode_q;
      case (state)
        S_STREAM_ID:
        begin
          stream_id_q <= stream_byte;
          error_q     <= 1'b0;
        end
        S_FLAGS1:
          if (stream_byte[7:6] != 2'b10)
            error_q <= 1'b1; // marker bits of the first flags byte
        S_FLAGS2:
        begin
          mode_q <= ts_mode_e'(stream_byte[7:6]);
          if (stream_byte[7:6] == TS_FORBIDDEN)
            error_q <= 1'b1;
        end
        S_HDR_LEN:
        begin
          hdl_q   <= stream_byte;
          error_q <= hdr_bad;
        end
        default: ;
      endcase
    end
  end

  assign ts_req  = '{valid: fwd_valid, mode: fwd_mode, data: fwd_data};
  assign hdr_rec = '{stream_id: stream_id_q, ts_mode: mode_q,
                     header_data_length: hdl_q, header_error: error_q};

endmodule

//--- hw/pts_dts_extractor.sv
`timescale 1ns/100ps
`include "pes_defines.svh"

module pts_dts_extractor (
  input  logic                       read_signal,
  input  logic                       rst_n,
  input  pes_stream_pkg::ts_req_t    ts_req,
  output logic                       ts_push,
  output pes_stream_pkg::ts_record_t ts_rec,
  output logic                       marker_fault
);
  import pes_stream_pkg::*;

  logic [3:0]  idx;
  logic [2:0]  pos;
  logic        in_dts;
  logic [3:0]  want_prefix;
  logic [3:0]  total;
  logic        byte_bad;
  logic        err_q;
  logic [32:0] pts_q;
  logic [32:0] dts_q;
  logic        has_dts_q;

  // drops one stream byte into its slice of a 33-bit timestamp
  function automatic logic [32:0] place(input logic [32:0] cur, input logic [2:0] p,
                                        input logic [7:0] b);
    logic [32:0] v;
    v = cur;
    case (p)
      3'd0: v[32:30] = b[3:1];
      3'd1: v[29:22] = b;
      3'd2: v[21:15] = b[7:1];
      3'd3: v[14:7]  = b;
      default: v[6:0] = b[7:1];
    endcase
    return v;
  endfunction

  assign in_dts      = (idx >= `PES_PTS_BYTES);
  assign pos         = in_dts ? 3'(idx - `PES_PTS_BYTES) : idx[2:0];
  assign total       = (ts_req.mode == TS_PTS_DTS) ? `PES_PTS_DTS_BYTES : `PES_PTS_BYTES;
  assign want_prefix = in_dts ? 4'b0001 : ((ts_req.mode == TS_PTS_DTS) ? 4'b0011 : 4'b0010);

  always_comb
  begin
    case (pos)
      3'd0:    byte_bad = (ts_req.data[7:4] != want_prefix) || !ts_req.data[0];
      3'd2:    byte_bad = !ts_req.data[0];
      3'd4:    byte_bad = !ts_req.data[0];
      default: byte_bad = 1'b0;
    endcase
  end

  always_ff @(posedge read_signal or negedge rst_n)
  begin
    if (!rst_n)
    begin
      idx          <= 4'd0;
      err_q        <= 1'b0;
      ts_push      <= 1'b0;
      marker_fault <= 1'b0;
    end
    else
    begin
      ts_push      <= 1'b0;
      marker_fault <= 1'b0;
      if (ts_req.valid)
      begin
        if (idx == total - 4'd1)
        begin
          idx          <= 4'd0;
          err_q        <= 1'b0;
          ts_push      <= !(err_q || byte_bad);
          marker_fault <= err_q || byte_bad; // one pulse per bad record
        end
        else
        begin
          idx   <= idx + 4'd1;
          err_q <= err_q || byte_bad;
        end
      end
    end
  end

  always_ff @(posedge read_signal)
  begin
    if (ts_req.valid)
    begin
      if (idx == 4'd0)
      begin
        dts_q     <= '0;
        has_dts_q <= (ts_req.mode == TS_PTS_DTS);
      end
      else if (in_dts)
        dts_q <= place(dts_q, pos, ts_req.data);
      if (!in_dts)
        pts_q <= place(pts_q, pos, ts_req.data);
    end
  end

  // faulty records never reach the queue so the flag is always clear here
  assign ts_rec = '{pts: pts_q, dts: dts_q, has_dts: has_dts_q, marker_error: 1'b0};

endmodule

//--- hw/event_queue.sv
`timescale 1ns/100ps

module event_queue #(
  parameter int  DEPTH     = 4,
  parameter type payload_t = logic [7:0]
) (
  input  logic       read_signal,
  input  logic       rst_n,
  input  logic       push,
  input  payload_t   push_data,
  input  logic       pop,
  output payload_t   head,
  output logic [3:0] count,
  output logic       overflow,
  input  logic       overflow_clr
);
  localparam int AW = $clog2(DEPTH);

  payload_t      mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic          full;
  logic          do_push;
  logic          do_pop;

  assign full    = (count == 4'(DEPTH));
  assign do_push = push && !full; // new records are lost while full
  assign do_pop  = pop && (count != 4'd0);

  always_ff @(posedge read_signal or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= 4'd0;
      overflow <= 1'b0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      count <= count + {3'd0, do_push} - {3'd0, do_pop};
      if (push && full)
        overflow <= 1'b1;
      else if (overflow_clr)
        overflow <= 1'b0;
    end
  end

  always_ff @(posedge read_signal)
  begin
    if (do_push)
      mem[wr_ptr] <= push_data;
  end

  assign head = mem[rd_ptr];

endmodule

//--- hw/pes_apb_regs.sv
`timescale 1ns/100ps
`include "pes_defines.svh"

module pes_apb_regs (
  input  logic                        read_signal,
  input  logic                        rst_n,
  input  pes_regs_pkg::apb_req_t      apb_in,
  output pes_regs_pkg::apb_rsp_t      apb_out,
  input  pes_stream_pkg::pes_header_t hdr_head,
  input  pes_stream_pkg::ts_record_t  ts_head,
  input  logic [3:0]                  hdr_count,
  input  logic [3:0]                  ts_count,
  input  logic                        hdr_ovf,
  input  logic                        ts_ovf,
  input  logic                        marker_fault,
  output logic                        hdr_pop,
  output logic                        ts_pop,
  output logic                        ovf_clr_hdr,
  output logic                        ovf_clr_ts
);
  import pes_regs_pkg::*;

  pes_status_t status;
  logic        access;
  logic        wr;
  logic        known;
  logic [31:0] rdata;
  logic [7:0]  err_cnt;

  assign access = apb_in.psel && apb_in.penable;
  assign wr     = access && apb_in.pwrite;
  assign status = '{reserved: '0, ts_ovf: ts_ovf, hdr_ovf: hdr_ovf,
                    ts_count: ts_count, hdr_count: hdr_count};

  // queue side acts on the edge that closes the access phase
  assign hdr_pop     = wr && (apb_in.paddr == `PES_REG_POP) && apb_in.pwdata[0];
  assign ts_pop      = wr && (apb_in.paddr == `PES_REG_POP) && apb_in.pwdata[1];
  assign ovf_clr_hdr = wr && (apb_in.paddr == `PES_REG_STATUS) && apb_in.pwdata[8];
  assign ovf_clr_ts  = wr && (apb_in.paddr == `PES_REG_STATUS) && apb_in.pwdata[9];

  always_ff @(posedge read_signal or negedge rst_n)
  begin
    if (!rst_n)
      err_cnt <= 8'd0;
    else if (marker_fault && (err_cnt != 8'hFF))
      err_cnt <= err_cnt + 8'd1; // saturates at 255
  end

  always_comb
  begin
    rdata = 32'd0;
    known = 1'b1;
    case (apb_in.paddr)
      `PES_REG_STATUS:  rdata = status;
      `PES_REG_HDR:     rdata = {13'd0, hdr_head};
      `PES_REG_PTS_LO:  rdata = ts_head.pts[31:0];
      `PES_REG_DTS_LO:  rdata = ts_head.dts[31:0];
      `PES_REG_TS_MISC: rdata = {29'd0, ts_head.has_dts, ts_head.dts[32], ts_head.pts[32]};
      `PES_REG_POP:     rdata = 32'd0;
      `PES_REG_ERRCNT:  rdata = {24'd0, err_cnt};
      default:          known = 1'b0;
    endcase
  end

  assign apb_out = '{prdata: rdata, pready: 1'b1, pslverr: access && !known};

endmodule

//--- hw/pes_timestamp_top.sv
`timescale 1ns/100ps
`include "pes_defines.svh"

module pes_timestamp_top (
  input  logic                   read_signal,
  input  logic                   rst_n,
  input  logic                   byte_valid,
  input  logic [7:0]             stream_byte,
  input  pes_regs_pkg::apb_req_t apb_in,
  output pes_regs_pkg::apb_rsp_t apb_out
);
  import pes_stream_pkg::*;

  ts_req_t     ts_req;
  logic        hdr_push;
  pes_header_t hdr_rec;
  pes_header_t hdr_head;
  logic        ts_push;
  ts_record_t  ts_rec;
  ts_record_t  ts_head;
  logic        marker_fault;
  logic [3:0]  hdr_count;
  logic [3:0]  ts_count;
  logic        hdr_ovf;
  logic        ts_ovf;
  logic        hdr_pop;
  logic        ts_pop;
  logic        ovf_clr_hdr;
  logic        ovf_clr_ts;

  pes_header_parser u_parser (
    .read_signal (read_signal),
    .rst_n       (rst_n),
    .byte_valid  (byte_valid),
    .stream_byte (stream_byte),
    .ts_req      (ts_req),
    .hdr_push    (hdr_push),
    .hdr_rec     (hdr_rec)
  );

  pts_dts_extractor u_extractor (
    .read_signal  (read_signal),
    .rst_n        (rst_n),
    .ts_req       (ts_req),
    .ts_push      (ts_push),
    .ts_rec       (ts_rec),
    .marker_fault (marker_fault)
  );

  event_queue #(.DEPTH(`PES_QUEUE_DEPTH), .payload_t(pes_header_t)) u_hdr_queue (
    .read_signal  (read_signal),
    .rst_n        (rst_n),
    .push         (hdr_push),
    .push_data    (hdr_rec),
    .pop          (hdr_pop),
    .head         (hdr_head),
    .count        (hdr_count),
    .overflow     (hdr_ovf),
    .overflow_clr (ovf_clr_hdr)
  );

  event_queue #(.DEPTH(`PES_QUEUE_DEPTH), .payload_t(ts_record_t)) u_ts_queue (
    .read_signal  (read_signal),
    .rst_n        (rst_n),
    .push         (ts_push),
    .push_data    (ts_rec),
    .pop          (ts_pop),
    .head         (ts_head),
    .count        (ts_count),
    .overflow     (ts_ovf),
    .overflow_clr (ovf_clr_ts)
  );

  pes_apb_regs u_regs (
    .read_signal  (read_signal),
    .rst_n        (rst_n),
    .apb_in       (apb_in),
    .apb_out      (apb_out),
    .hdr_head     (hdr_head),
    .ts_head      (ts_head),
    .hdr_count    (hdr_count),
    .ts_count     (ts_count),
    .hdr_ovf      (hdr_ovf),
    .ts_ovf       (ts_ovf),
    .marker_fault (marker_fault),
    .hdr_pop      (hdr_pop),
    .ts_pop       (ts_pop),
    .ovf_clr_hdr  (ovf_clr_hdr),
    .ovf_clr_ts   (ovf_clr_ts)
  );

endmodule

//--- verif/pes_tb_table.svh
`ifndef PES_TB_TABLE_SVH
`define PES_TB_TABLE_SVH

// stream bytes are right-aligned in data, so the first byte sent is the most significant
typedef struct packed {
  logic [7:0]   n_fill;
  logic [7:0]   n_bytes;
  logic [255:0] data;
  logic         hdr_exp;
  pes_header_t  hdr;
  logic         ts_exp;
  ts_record_t   ts;
  logic         fault;
  logic         drain;
} stim_entry_t;

localparam int NUM_TESTS = 12;

// each row gives n_fill, n_bytes, stream, hdr_exp, hdr, ts_exp, ts, fault and drain
localparam stim_entry_t TESTS [NUM_TESTS] = '{
  '{8'd0, 8'd16, 256'h000001E0_00108080_072FA55B_3C81FFFF, // PTS only with two stuffing bytes
    1'b1, '{8'hE0, TS_PTS, 8'h07, 1'b0},
    1'b1, '{33'h1_E956_9E40, 33'h0, 1'b0, 1'b0}, 1'b0, 1'b1},
  '{8'd0, 8'd19, 256'h000001C0_002084C0_0A331235_789B19FE_ABCDEF, // PTS and DTS
    1'b1, '{8'hC0, TS_PTS_DTS, 8'h0A, 1'b0},
    1'b1, '{33'h0_448D_3C4D, 33'h1_3FAA_E6F7, 1'b1, 1'b0}, 1'b0, 1'b1},
  '{8'd0, 8'd12, 256'h000001BD_00088000_03FFFFFF, // no timestamps, stuffing only
    1'b1, '{8'hBD, TS_NONE, 8'h03, 1'b0},
    1'b0, '0, 1'b0, 1'b1},
  '{8'd0, 8'd14, 256'h000001E0_00108080_05210000_0001, // marker bit of byte 2 cleared
    1'b1, '{8'hE0, TS_PTS, 8'h05, 1'b0},
    1'b0, '0, 1'b1, 1'b1},
  '{8'd0, 8'd14, 256'h000001E0_00108080_05310001_0001, // prefix 0011 on a PTS-only header
    1'b1, '{8'hE0, TS_PTS, 8'h05, 1'b0},
    1'b0, '0, 1'b1, 1'b1},
  '{8'd0, 8'd9, 256'h000001E0_00088040_00, // forbidden flags 01
    1'b1, '{8'hE0, TS_FORBIDDEN, 8'h00, 1'b1},
    1'b0, '0, 1'b0, 1'b1},
  '{8'd6, 8'd17, 256'h000002_000001E0_00108080_05258001_02FF, // false prefix then real one
    1'b1, '{8'hE0, TS_PTS, 8'h05, 1'b0},
    1'b1, '{33'h0_A000_017F, 33'h0, 1'b0, 1'b0}, 1'b0, 1'b1},
  '{8'd0, 8'd14, 256'h000001C0_000D8080_05210001_0023, // queue fill starts here
    1'b1, '{8'hC0, TS_PTS, 8'h05, 1'b0},
    1'b1, '{33'h0_0000_0011, 33'h0, 1'b0, 1'b0}, 1'b0, 1'b0},
  '{8'd0, 8'd14, 256'h000001C1_000D8080_05210001_0045,
    1'b1, '{8'hC1, TS_PTS, 8'h05, 1'b0},
    1'b1, '{33'h0_0000_0022, 33'h0, 1'b0, 1'b0}, 1'b0, 1'b0},
  '{8'd0, 8'd14, 256'h000001C2_000D8080_05210001_0067,
    1'b1, '{8'hC2, TS_PTS, 8'h05, 1'b0},
    1'b1, '{33'h0_0000_0033, 33'h0, 1'b0, 1'b0}, 1'b0, 1'b0},
  '{8'd0, 8'd14, 256'h000001C3_000D8080_05210001_0089,
    1'b1, '{8'hC3, TS_PTS, 8'h05, 1'b0},
    1'b1, '{33'h0_0000_0044, 33'h0, 1'b0, 1'b0}, 1'b0, 1'b0},
  '{8'd0, 8'd14, 256'h000001C4_000D8080_05210001_00AB, // one past full, gets dropped
    1'b1, '{8'hC4, TS_PTS, 8'h05, 1'b0},
    1'b1, '{33'h0_0000_0055, 33'h0, 1'b0, 1'b0}, 1'b0, 1'b1}
};

`endif

//--- verif/tb_pes_timestamp.sv
`timescale 1ns/100ps
`include "pes_defines.svh"

module tb_pes_timestamp;
  import pes_stream_pkg::*;
  import pes_regs_pkg::*;

  `include "pes_tb_table.svh"

  logic        read_signal;
  logic        rst_n;
  logic        byte_valid;
  logic [7:0]  stream_byte;
  apb_req_t    apb_in;
  apb_rsp_t    apb_out;

  pes_header_t hdr_model [$];
  ts_record_t  ts_model [$];
  logic        hdr_ovf_exp;
  logic        ts_ovf_exp;
  logic [7:0]  err_exp;

  pes_timestamp_top UUT (
    .read_signal (read_signal),
    .rst_n       (rst_n),
    .byte_valid  (byte_valid),
    .stream_byte (stream_byte),
    .apb_in      (apb_in),
    .apb_out     (apb_out)
  );

  initial
  begin
    read_signal = 1'b0;
    forever #10 read_signal = ~read_signal;
  end

  task automatic stop_on_error();
    $display("Simulation failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_header(input pes_header_t got, input pes_header_t exp);
    if (got !== exp)
    begin
      $display("Error: hdr_head got 0x%h, expected 0x%h", got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_ts(input ts_record_t got, input ts_record_t exp);
    if (got !== exp)
    begin
      $display("Error: ts_head got 0x%h, expected 0x%h", got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_status(input pes_status_t got, input pes_status_t exp);
    if (got !== exp)
    begin
      $display("Error: status got 0x%h, expected 0x%h", got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_errcnt(input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp)
    begin
      $display("Error: err_cnt got 0x%h, expected 0x%h", got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_rsp(input apb_rsp_t got, input apb_rsp_t exp);
    if (got !== exp)
    begin
      $display("Error: apb_out got 0x%h, expected 0x%h", got, exp);
      stop_on_error();
    end
  endtask

  // setup phase, access phase, then back to idle after the closing edge
  task automatic apb_access(input logic is_write, input logic [`PES_APB_AW-1:0] addr,
                            input logic [31:0] wdata, output apb_rsp_t rsp);
    @(posedge read_signal);
    #2;
    apb_in = '{psel: 1'b1, penable: 1'b0, pwrite: is_write, paddr: addr, pwdata: wdata};
    @(posedge read_signal);
    #2;
    apb_in.penable = 1'b1;
    @(negedge read_signal);
    rsp = apb_out; // settled halfway through the access phase
    @(posedge read_signal);
    #2;
    apb_in = '0;
  endtask

  task automatic send_byte(input logic [7:0] b);
    @(posedge read_signal);
    #2;
    byte_valid  = 1'b1;
    stream_byte = b;
  endtask

  task automatic end_stream();
    @(posedge read_signal);
    #2;
    byte_valid  = 1'b0;
    stream_byte = 8'h00;
  endtask

  function automatic pes_status_t expected_status();
    pes_status_t s;
    s           = '0;
    s.hdr_count = 4'(hdr_model.size());
    s.ts_count  = 4'(ts_model.size());
    s.hdr_ovf   = hdr_ovf_exp;
    s.ts_ovf    = ts_ovf_exp;
    return s;
  endfunction

  // polls until STATUS and ERRCNT match the model or the poll budget runs out
  task automatic wait_for_status();
    apb_rsp_t st;
    apb_rsp_t ec;
    int       polls;
    logic     settled;
    polls   = 0;
    settled = 1'b0;
    while (!settled && (polls < 40))
    begin
      apb_access(1'b0, `PES_REG_STATUS, 32'd0, st);
      apb_access(1'b0, `PES_REG_ERRCNT, 32'd0, ec);
      settled = (st.prdata == 32'(expected_status())) && (ec.prdata[7:0] == err_exp);
      polls++;
    end
    check_status(pes_status_t'(st.prdata), expected_status());
    check_errcnt(ec.prdata[7:0], err_exp);
  endtask

  task automatic read_ts_record(output ts_record_t rec);
    apb_rsp_t pts_lo;
    apb_rsp_t dts_lo;
    apb_rsp_t misc;
    apb_access(1'b0, `PES_REG_PTS_LO, 32'd0, pts_lo);
    apb_access(1'b0, `PES_REG_DTS_LO, 32'd0, dts_lo);
    apb_access(1'b0, `PES_REG_TS_MISC, 32'd0, misc);
    rec.pts          = {misc.prdata[0], pts_lo.prdata};
    rec.dts          = {misc.prdata[1], dts_lo.prdata};
    rec.has_dts      = misc.prdata[2];
    rec.marker_error = 1'b0; // not visible in the register map
  endtask

  task automatic drain_queues();
    apb_rsp_t   rsp;
    ts_record_t rec;
    while (hdr_model.size() > 0)
    begin
      apb_access(1'b0, `PES_REG_HDR, 32'd0, rsp);
      check_header(pes_header_t'(rsp.prdata[18:0]), hdr_model.pop_front());
      apb_access(1'b1, `PES_REG_POP, 32'h1, rsp);
    end
    while (ts_model.size() > 0)
    begin
      read_ts_record(rec);
      check_ts(rec, ts_model.pop_front());
      apb_access(1'b1, `PES_REG_POP, 32'h2, rsp);
    end
    if (hdr_ovf_exp || ts_ovf_exp)
    begin
      apb_access(1'b1, `PES_REG_STATUS, 32'h300, rsp);
      hdr_ovf_exp = 1'b0;
      ts_ovf_exp  = 1'b0;
    end
    wait_for_status();
  endtask

  initial
  begin
    int          i;
    int          k;
    stim_entry_t t;
    apb_rsp_t    rsp;
    apb_rsp_t    bus_err;
    void'($urandom(32'hef5e_f0ce));
    rst_n       = 1'b0;
    byte_valid  = 1'b0;
    stream_byte = 8'h00;
    apb_in      = '0;
    hdr_ovf_exp = 1'b0;
    ts_ovf_exp  = 1'b0;
    err_exp     = 8'd0;
    repeat (16) @(posedge read_signal);
    #2;
    rst_n = 1'b1;

    bus_err = '{prdata: 32'd0, pready: 1'b1, pslverr: 1'b1};
    apb_access(1'b0, 8'h3C, 32'd0, rsp); // unmapped offset
    check_rsp(rsp, bus_err);

    for (i = 0; i < NUM_TESTS; i++)
    begin
      t = TESTS[i];
      repeat (t.n_fill) send_byte(8'($urandom_range(255, 1))); // never zero, so never a prefix
      for (k = 0; k < t.n_bytes; k++)
        send_byte(t.data[8*(t.n_bytes-1-k) +: 8]);
      end_stream();
      if (t.hdr_exp)
      begin
        if (hdr_model.size() < `PES_QUEUE_DEPTH)
          hdr_model.push_back(t.hdr);
        else
          hdr_ovf_exp = 1'b1;
      end
      if (t.ts_exp)
      begin
        if (ts_model.size() < `PES_QUEUE_DEPTH)
          ts_model.push_back(t.ts);
        else
          ts_ovf_exp = 1'b1;
      end
      if (t.fault)
        err_exp = err_exp + 8'd1;
      wait_for_status();
      if (t.drain)
        drain_queues();
    end
    $display("Simulation passed");
    $finish;
  end

  initial
  begin
    int limit;
    int n;
    limit = 200;
    for (n = 0; n < NUM_TESTS; n++)
      limit += 4 * (int'(TESTS[n].n_bytes) + int'(TESTS[n].n_fill));
    repeat (limit) @(posedge read_signal);
    $display("Watchdog expired after %0d cycles before the test sequence finished", limit);
    stop_on_error();
  end

endmodule

//--- sources.f
+incdir+hw
+incdir+verif
hw/pes_stream_pkg.sv
hw/pes_regs_pkg.sv
hw/pes_header_parser.sv
hw/pts_dts_extractor.sv
hw/event_queue.sv
hw/pes_apb_regs.sv
hw/pes_timestamp_top.sv
verif/tb_pes_timestamp.sv

//--- run_sim.sh
#!/bin/sh
# build and run the PES timestamp testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary -Wno-fatal -f sources.f --top-module tb_pes_timestamp \
  -Mdir obj_dir -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "^Simulation passed$" sim.log; then
  echo "result: pass"
else
  echo "result: fail, see sim.log"
  exit 1
fi
